// ==== vlog.f ====
hw/fifo_pkg.sv
hw/lfsr_pointer.sv
hw/fifo_ram.sv
hw/fifo_status.sv
hw/fifoctlr_cc.sv
test/fifoctlr_cc_tb.sv

// ==== Makefile ====
# Verilator build and run of the FIFO testbench.

VERILATOR ?= verilator
TOP       ?= fifoctlr_cc_tb
RTL_TOP   ?= fifoctlr_cc
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/fifoctlr_cc_tb.sv ====
`timescale 1ns/1ps

module fifoctlr_cc_tb;

   import fifo_pkg::*;

   // ######################################################################
   // run lengths
   // ######################################################################

   localparam int clock_period      = 8;     // ns.
   localparam int reset_cycles      = 8;     // reset held this long.
   localparam int idle_cycles       = 4;     // quiet gap between phases.
   localparam int empty_read_cycles = 16;    // reads against an empty buffer.
   localparam int fill_cycles       = 520;   // write attempts, more than the depth.
   localparam int drain_cycles      = 520;   // read attempts, more than the depth.
   localparam int segment_cycles    = 500;   // one bias setting of mixed traffic.
   localparam int segment_count     = 6;     // bias settings in the mixed phase.
   localparam int mixed_cycles      = segment_cycles * segment_count;
   localparam int total_cycles      = reset_cycles + 4 * idle_cycles + empty_read_cycles +
                                      fill_cycles + drain_cycles + mixed_cycles;

   // percent chance of each enable per mixed segment.
   // the order climbs to full, then falls back to empty.
   localparam int write_bias [segment_count] = '{50, 80, 95, 20, 5, 50};
   localparam int read_bias  [segment_count] = '{50, 20, 5, 80, 95, 50};

   logic   clock;         // dut clock.
   logic   fifo_gsr;      // dut reset.
   logic   read_enable;   // read request.
   logic   write_enable;  // write request.
   data_t  write_data;    // word offered.
   data_t  read_data;     // word returned.
   logic   full;          // dut full flag.
   logic   empty;         // dut empty flag.
   level_t fifo_level;    // dut fill level.

   data_t  model_queue [$];  // expected contents, oldest first.
   count_t model_count;      // expected occupancy.
   logic   model_full;       // expected full flag.
   logic   model_empty;      // expected empty flag.
   data_t  model_read_data;  // expected output register.
   string  phase_name;       // current phase, shown on errors.

   fifoctlr_cc fifoctlr_cc_inst (
      .clock        (clock),
      .fifo_gsr     (fifo_gsr),
      .read_enable  (read_enable),
      .write_enable (write_enable),
      .write_data   (write_data),
      .read_data    (read_data),
      .full         (full),
      .empty        (empty),
      .fifo_level   (fifo_level)
   );

   // ######################################################################
   // clock and watchdog
   // ######################################################################

   initial
   begin
      clock = 1'b0;
      forever #(clock_period / 2) clock = ~clock;  // 8 ns period.
   end

   initial
   begin
      #(2 * total_cycles * clock_period);  // twice the expected run.
      stop_with_failure("simulation did not finish in time");
   end

   // ######################################################################
   // helpers
   // ######################################################################

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   // next model state from the occupancy, the flags and the raw enables.
   function automatic void predict_next
   (
      input  count_t occ,
      input  logic   full_now,
      input  logic   empty_now,
      input  logic   rd_en,
      input  logic   wr_en,
      output count_t occ_next,
      output logic   full_next,
      output logic   empty_next,
      output logic   rd_ok,
      output logic   wr_ok
   );
      rd_ok    = rd_en && !empty_now;  // read against empty is dropped.
      wr_ok    = wr_en && !full_now;   // write against full is dropped.
      occ_next = occ;
      if (wr_ok && !rd_ok)
         occ_next = occ + count_t'(1);
      else if (rd_ok && !wr_ok)
         occ_next = occ - count_t'(1);
      empty_next = !wr_en && ((occ == count_t'(0)) || ((occ == count_t'(1)) && rd_en));
      full_next  = !rd_en && ((occ == fifo_depth) ||
                              ((occ == fifo_depth - count_t'(1)) && wr_en));
   endfunction

   task automatic drive_cycle(input logic rd, input logic wr, input data_t data);
      @(negedge clock);
      read_enable  = rd;    // levels change on the falling edge.
      write_enable = wr;
      write_data   = data;
   endtask

   // ######################################################################
   // model update and compare
   // ######################################################################

   initial
   begin : compare_process
      logic   rd_en;
      logic   wr_en;
      data_t  wr_word;
      count_t occ_next;
      logic   full_next;
      logic   empty_next;
      logic   rd_ok;
      logic   wr_ok;
      forever
      begin
         @(posedge clock);
         rd_en   = read_enable;  // stable since the falling edge.
         wr_en   = write_enable;
         wr_word = write_data;
         if (fifo_gsr)
         begin
            model_count     = '0;
            model_full      = 1'b1;
            model_empty     = 1'b1;
            model_read_data = '0;
            model_queue.delete();
         end
         else
         begin
            predict_next(model_count, model_full, model_empty, rd_en, wr_en,
                         occ_next, full_next, empty_next, rd_ok, wr_ok);
            if (rd_ok)
            begin
               if (model_queue.size() == 0)
                  stop_with_failure("a read was accepted while the model held no data");
               model_read_data = model_queue.pop_front();  // oldest word.
            end
            if (wr_ok)
               model_queue.push_back(wr_word);
            model_count = occ_next;
            model_full  = full_next;
            model_empty = empty_next;
         end
         #1;  // let the register updates settle.
         check_value({phase_name, " empty"}, 32'(model_empty), 32'(empty));
         check_value({phase_name, " full"}, 32'(model_full), 32'(full));
         check_value({phase_name, " level"}, 32'(model_count / 32), 32'(fifo_level));
         check_value({phase_name, " read_data"}, 32'(model_read_data), 32'(read_data));
      end
   end

   // ######################################################################
   // stimulus phases
   // ######################################################################

   initial
   begin
      void'($urandom(32'h7d8f));  // one seed for the run.
      phase_name   = "reset";
      fifo_gsr     = 1'b1;
      read_enable  = 1'b0;
      write_enable = 1'b0;
      write_data   = '0;
      repeat (reset_cycles) @(negedge clock);
      fifo_gsr = 1'b0;

      phase_name = "after reset";  // full must clear on the first quiet edge.
      repeat (idle_cycles) drive_cycle(1'b0, 1'b0, '0);

      phase_name = "read empty";  // requests dropped, output holds.
      repeat (empty_read_cycles) drive_cycle(1'b1, 1'b0, data_t'($urandom));

      phase_name = "fill";
      repeat (fill_cycles) drive_cycle(1'b0, 1'b1, data_t'($urandom));
      repeat (idle_cycles) drive_cycle(1'b0, 1'b0, '0);
      @(posedge clock);
      #2;
      check_value("fill full flag", 32'd1, 32'(full));
      check_value("fill top level", 32'd15, 32'(fifo_level));

      phase_name = "drain";
      repeat (drain_cycles) drive_cycle(1'b1, 1'b0, data_t'($urandom));
      repeat (idle_cycles) drive_cycle(1'b0, 1'b0, '0);
      @(posedge clock);
      #2;
      check_value("drain empty flag", 32'd1, 32'(empty));
      check_value("drain level", 32'd0, 32'(fifo_level));

      for (int seg = 0; seg < segment_count; seg++)
      begin
         phase_name = $sformatf("mixed %0d", seg);
         repeat (segment_cycles)
            drive_cycle($urandom_range(99) < read_bias[seg],
                        $urandom_range(99) < write_bias[seg],
                        data_t'($urandom));
      end

      phase_name = "final";
      repeat (idle_cycles) drive_cycle(1'b0, 1'b0, '0);
      @(posedge clock);
      #2;
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== hw/fifoctlr_cc.sv ====
`timescale 1ns/1ps

module fifoctlr_cc
(
   input  logic             clock,         // common clock.
   input  logic             fifo_gsr,      // async reset, active high.
   input  logic             read_enable,   // read request level.
   input  logic             write_enable,  // write request level.
   input  fifo_pkg::data_t  write_data,    // word to write.
   output fifo_pkg::data_t  read_data,     // word read, one cycle late.
   output logic             full,          // no room for a write.
   output logic             empty,         // nothing to read.
   output fifo_pkg::level_t fifo_level     // occupancy divided by 32.
);

   import fifo_pkg::*;

   logic  read_allow;   // accepted read.
   logic  write_allow;  // accepted write.
   addr_t read_addr;    // read pointer state.
   addr_t write_addr;   // write pointer state.

   // ######################################################################
   // flags, gating and fill level
   // ######################################################################

   fifo_status status_inst (
      .clock        (clock),
      .fifo_gsr     (fifo_gsr),
      .read_enable  (read_enable),
      .write_enable (write_enable),
      .read_allow   (read_allow),
      .write_allow  (write_allow),
      .full         (full),
      .empty        (empty),
      .fifo_level   (fifo_level)
   );

   // ######################################################################
   // address pointers, same sequence for both
   // ######################################################################

   lfsr_pointer read_pointer_inst (
      .clock    (clock),
      .fifo_gsr (fifo_gsr),
      .advance  (read_allow),   // steps on each accepted read.
      .addr     (read_addr)
   );

   lfsr_pointer write_pointer_inst (
      .clock    (clock),
      .fifo_gsr (fifo_gsr),
      .advance  (write_allow),  // steps on each accepted write.
      .addr     (write_addr)
   );

   // ######################################################################
   // storage
   // ######################################################################

   fifo_ram ram_inst (
      .clock       (clock),
      .fifo_gsr    (fifo_gsr),
      .write_allow (write_allow),
      .write_addr  (write_addr),
      .write_data  (write_data),
      .read_allow  (read_allow),
      .read_addr   (read_addr),
      .read_data   (read_data)
   );

endmodule

// ==== hw/fifo_status.sv ====
`timescale 1ns/1ps

module fifo_status
(
   input  logic             clock,         // common clock.
   input  logic             fifo_gsr,      // async reset, active high.
   input  logic             read_enable,   // read request level.
   input  logic             write_enable,  // write request level.
   output logic             read_allow,    // read accepted.
   output logic             write_allow,   // write accepted.
   output logic             full,          // registered full flag.
   output logic             empty,         // registered empty flag.
   output fifo_pkg::level_t fifo_level     // coarse fill level.
);

   import fifo_pkg::*;

   count_t count;        // words currently held.
   logic   empty_next;   // look-ahead empty condition.
   logic   full_next;    // look-ahead full condition.

   // ######################################################################
   // request gating
   // ######################################################################

   // requests against a set flag are simply dropped.
   assign read_allow  = read_enable & ~empty;   // never read an empty buffer.
   assign write_allow = write_enable & ~full;   // never overwrite unread data.

   // ######################################################################
   // occupancy counter
   // ######################################################################

   always_ff @(posedge clock or posedge fifo_gsr)
   begin
      if (fifo_gsr)
      begin
         count <= '0;  // nothing stored.
      end
      else if (write_allow && !read_allow)
      begin
         count <= count + count_t'(1);  // write alone.
      end
      else if (read_allow && !write_allow)
      begin
         count <= count - count_t'(1);  // read alone.
      end
   end

   // ######################################################################
   // look-ahead flags
   // ######################################################################

   // uses the raw enables, so a flag may stay set one cycle too long.
   assign empty_next = !write_enable &&
                       ((count == '0) || ((count == count_t'(1)) && read_enable));

   assign full_next  = !read_enable &&
                       ((count == fifo_depth) ||
                        ((count == fifo_depth - count_t'(1)) && write_enable));

   // both flags set in reset, so nothing is accepted until released.
   always_ff @(posedge clock or posedge fifo_gsr)
   begin
      if (fifo_gsr)
      begin
         empty <= 1'b1;  // block reads.
         full  <= 1'b1;  // block writes, clears on the first edge.
      end
      else
      begin
         empty <= empty_next;  // about to be empty.
         full  <= full_next;   // about to be full.
      end
   end

   // ######################################################################
   // fill level
   // ######################################################################

   // occupancy divided by 32, taken straight from the counter register.
   assign fifo_level = count[$bits(count_t)-1 -: $bits(level_t)];

endmodule

// ==== hw/fifo_ram.sv ====
`timescale 1ns/1ps

module fifo_ram
(
   input  logic            clock,        // common clock.
   input  logic            fifo_gsr,     // async reset, active high.
   input  logic            write_allow,  // accepted write this edge.
   input  fifo_pkg::addr_t write_addr,   // write pointer.
   input  fifo_pkg::data_t write_data,   // word to store.
   input  logic            read_allow,   // accepted read this edge.
   input  fifo_pkg::addr_t read_addr,    // read pointer.
   output fifo_pkg::data_t read_data     // registered read word.
);

   import fifo_pkg::*;

   // ######################################################################
   // storage, one entry per pointer state
   // ######################################################################

   data_t mem [2**$bits(addr_t)];  // 512 x 8, one entry left unused.

   // write port.
   always_ff @(posedge clock)
   begin
      if (write_allow)
      begin
         mem[write_addr] <= write_data;  // store the word.
      end
   end

   // read port with output register, holds when idle.
   // the pointers never meet on a cycle that reads and writes.
   always_ff @(posedge clock or posedge fifo_gsr)
   begin
      if (fifo_gsr)
      begin
         read_data <= '0;  // clear output word.
      end
      else if (read_allow)
      begin
         read_data <= mem[read_addr];  // one cycle of read latency.
      end
   end

endmodule

// ==== hw/lfsr_pointer.sv ====
`timescale 1ns/1ps

module lfsr_pointer
(
   input  logic            clock,      // common clock.
   input  logic            fifo_gsr,   // async reset, active high.
   input  logic            advance,    // step to the next address.
   output fifo_pkg::addr_t addr        // current address.
);

   import fifo_pkg::*;

   // ######################################################################
   // xnor feedback shift register
   // ######################################################################

   logic feedback;  // new bit shifted in at the bottom.

   // xnor keeps all zeros legal, so the lockup state is all ones.
   assign feedback = ~(addr[lfsr_tap_high] ^ addr[lfsr_tap_low]);  // tap mix.

   // 511 distinct states before it wraps.
   always_ff @(posedge clock or posedge fifo_gsr)
   begin
      if (fifo_gsr)
      begin
         addr <= '0;  // start of the sequence.
      end
      else if (advance)
      begin
         addr <= {addr[$bits(addr_t)-2:0], feedback};  // shift toward msb.
      end
   end

endmodule

// ==== hw/fifo_pkg.sv ====
package fifo_pkg;

   // ######################################################################
   // word and address widths
   // ######################################################################

   typedef logic [7:0] data_t;   // one stored word.
   typedef logic [8:0] addr_t;   // ram address and pointer state.
   typedef logic [8:0] count_t;  // occupancy, 0 up to the usable depth.
   typedef logic [3:0] level_t;  // coarse fill level, top bits of count.

   // ######################################################################
   // depth and pointer feedback
   // ######################################################################

   // the pointers are lfsrs, so one of the 512 locations is never visited.
   localparam count_t fifo_depth = 9'd511;  // largest usable occupancy.

   // taps for the xnor feedback of the 9-bit maximal length sequence.
   localparam int lfsr_tap_high = 8;  // upper tap.
   localparam int lfsr_tap_low  = 4;  // lower tap.

endpackage
